//--- common/cci_req_if.sv
`timescale 1ns/1ps

// One buffer head as seen by the scheduler.
// The buffer presents the oldest request and the scheduler pops it with deq
interface cci_req_if import cci_shim_pkg::*; ();

    // Request fields taken straight from the FIFO head
    cci_hdr_t  hdr;
    cci_data_t data;
    req_kind_t kind;

    // High exactly when the buffer holds at least one request
    logic valid;

    // Removes the head at the next rising edge.
    // Only legal while valid is high
    logic deq;

    // The buffer side owns the request fields
    modport buffer (
        output hdr,
        output data,
        output kind,
        output valid,
        input  deq
    );

    // The scheduler side reads the head and decides when to pop it
    modport scheduler (
        input  hdr,
        input  data,
        input  kind,
        input  valid,
        output deq
    );

endinterface

//--- common/cci_shim_pkg.sv
package cci_shim_pkg;

    // ========================================
    // Widths
    // ========================================

    // Header and data widths are narrower than a production link
    localparam int HDR_WIDTH  = 16;
    localparam int DATA_WIDTH = 64;

    // ========================================
    // Channel buffers
    // ========================================

    // Entries held by each channel buffer
    localparam int BUF_DEPTH = 8;

    // Almost-full is raised once free slots drop to this value or below
    localparam int ALM_FULL_SLOTS = 4;

    // Read and write pointers index one of BUF_DEPTH slots
    localparam int BUF_PTR_WIDTH = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

    // The count must reach BUF_DEPTH itself, so it needs one extra value
    localparam int BUF_COUNT_WIDTH = $clog2(BUF_DEPTH + 1);

    // Channel 0 stores only a header
    localparam int C0_ENTRY_BITS = HDR_WIDTH;

    // Channel 1 stores header, data and the write and interrupt valid bits
    localparam int C1_ENTRY_BITS = HDR_WIDTH + DATA_WIDTH + 2;

    // ========================================
    // Types
    // ========================================

    typedef logic [HDR_WIDTH-1:0]       cci_hdr_t;
    typedef logic [DATA_WIDTH-1:0]      cci_data_t;
    typedef logic [1:0]                 req_kind_t;
    typedef logic [BUF_COUNT_WIDTH-1:0] buf_count_t;

    // Request kinds presented on the host port
    localparam req_kind_t KIND_READ  = 2'd0;
    localparam req_kind_t KIND_WRITE = 2'd1;
    localparam req_kind_t KIND_INTR  = 2'd2;

    // The scheduler remembers which channel wins the next tie
    typedef enum logic {
        PREFER_C0,
        PREFER_C1
    } arb_state_t;

endpackage

//--- dv/cci_shim_checks.svh
`ifndef CCI_SHIM_CHECKS_SVH
`define CCI_SHIM_CHECKS_SVH

// ========================================
// Reference model
// ========================================

// Channel that the host port should offer next, high for channel 1.
// A request that waits for ready keeps its channel, a tie goes to the
// preferred channel and a lone valid head wins on its own
function automatic logic pick_channel(input logic c0_valid, input logic c1_valid,
                                      input arb_state_t pref, input logic held,
                                      input logic held_c1);
    if (held) begin
        return held_c1;
    end
    if (c0_valid && c1_valid) begin
        return (pref == PREFER_C1);
    end
    return c1_valid;
endfunction

// Almost-full expected for a buffer that holds this many requests
function automatic logic expect_alm_full(input int held_count);
    return (BUF_DEPTH - held_count) <= ALM_FULL_SLOTS;
endfunction

// ========================================
// Compare tasks
// ========================================

task automatic check_hdr(input string what, input cci_hdr_t expected, input cci_hdr_t actual);
    if (actual !== expected) begin
        $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, expected, actual);
        $display("TEST RESULT: FAIL");
        $fatal(1, "host request header differs from the model");
    end
endtask

task automatic check_data(input string what, input cci_data_t expected, input cci_data_t actual);
    if (actual !== expected) begin
        $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, expected, actual);
        $display("TEST RESULT: FAIL");
        $fatal(1, "host request data differs from the model");
    end
endtask

task automatic check_kind(input string what, input req_kind_t expected, input req_kind_t actual);
    if (actual !== expected) begin
        $display("Mismatch in %s (%s): expected %0d, actual %0d", test_name, what, expected, actual);
        $display("TEST RESULT: FAIL");
        $fatal(1, "host request kind differs from the model");
    end
endtask

// Single bits such as valid, almost-full and the grant order
task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("Mismatch in %s (%s): expected %b, actual %b", test_name, what, expected, actual);
        $display("TEST RESULT: FAIL");
        $fatal(1, "flag differs from the model");
    end
endtask

`endif

//--- dv/cci_shim_tb.sv
`timescale 1ns/1ps

// Testbench for the request shim.
// The initial block drives the accelerator and host ready, while a process on
// the falling edge follows every cycle with a model of both buffers
module cci_shim_tb import cci_shim_pkg::*; ();

    logic      clk = 1'b0;
    logic      reset;
    cci_hdr_t  c0_tx_hdr;
    logic      c0_tx_rd_valid;
    logic      c0_tx_alm_full;
    cci_hdr_t  c1_tx_hdr;
    cci_data_t c1_tx_data;
    logic      c1_tx_wr_valid;
    logic      c1_tx_ir_valid;
    logic      c1_tx_alm_full;
    logic      host_req_valid;
    cci_hdr_t  host_req_hdr;
    cci_data_t host_req_data;
    req_kind_t host_req_kind;
    logic      host_req_ready;

    integer seed;
    string  test_name;
    int     issued_count;
    int     recv_count;
    logic   record_grants;

    // Model of the buffer contents and the scheduler preference
    cci_hdr_t   c0_q[$];
    cci_hdr_t   c1_hdr_q[$];
    cci_data_t  c1_data_q[$];
    req_kind_t  c1_kind_q[$];
    logic       grant_q[$];
    arb_state_t pref_model;
    logic       held;
    logic       held_c1;

    `include "cci_shim_checks.svh"

    cci_shim_top DUT (
        .clk            (clk),
        .reset          (reset),
        .c0_tx_hdr      (c0_tx_hdr),
        .c0_tx_rd_valid (c0_tx_rd_valid),
        .c0_tx_alm_full (c0_tx_alm_full),
        .c1_tx_hdr      (c1_tx_hdr),
        .c1_tx_data     (c1_tx_data),
        .c1_tx_wr_valid (c1_tx_wr_valid),
        .c1_tx_ir_valid (c1_tx_ir_valid),
        .c1_tx_alm_full (c1_tx_alm_full),
        .host_req_valid (host_req_valid),
        .host_req_hdr   (host_req_hdr),
        .host_req_data  (host_req_data),
        .host_req_kind  (host_req_kind),
        .host_req_ready (host_req_ready)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // ========================================
    // Stimulus helpers
    // ========================================

    // Moves to 1 ns after the next rising edge with all request valids low
    task automatic next_cycle();
        @(posedge clk);
        #1;
        c0_tx_rd_valid = 1'b0;
        c1_tx_wr_valid = 1'b0;
        c1_tx_ir_valid = 1'b0;
    endtask

    // The accelerator holds back while a channel reports almost-full
    task automatic issue_c0();
        if (!c0_tx_alm_full) begin
            c0_tx_hdr      = cci_hdr_t'($random(seed));
            c0_tx_rd_valid = 1'b1;
            issued_count++;
        end
    endtask

    task automatic issue_c1(input logic as_write);
        if (!c1_tx_alm_full) begin
            c1_tx_hdr  = cci_hdr_t'($random(seed));
            c1_tx_data = cci_data_t'({$random(seed), $random(seed)});
            if (as_write) begin
                c1_tx_wr_valid = 1'b1;
            end else begin
                c1_tx_ir_valid = 1'b1;
            end
            issued_count++;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (8) next_cycle();
        reset = 1'b0;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while %s during %s", what, test_name);
        $display("TEST RESULT: FAIL");
        $fatal(1, "wait loop ran out of cycles");
    endtask

    function automatic logic channels_filled(input logic use_c0, input logic use_c1);
        return (c0_tx_alm_full || !use_c0) && (c1_tx_alm_full || !use_c1);
    endfunction

    // Issues on the chosen channels until each one reports almost-full
    task automatic fill_channels(input logic use_c0, input logic use_c1);
        int n;
        n = 0;
        while (!channels_filled(use_c0, use_c1) && n < 40) begin
            if (use_c0) issue_c0();
            if (use_c1) issue_c1(($random(seed) & 1) != 0);
            next_cycle();
            n++;
        end
        if (!channels_filled(use_c0, use_c1)) report_timeout("filling the buffers");
    endtask

    // Opens the host port until the model and the DUT hold nothing
    task automatic drain();
        int n;
        n = 0;
        host_req_ready = 1'b1;
        while ((c0_q.size() != 0 || c1_hdr_q.size() != 0 || host_req_valid) && n < 200) begin
            next_cycle();
            n++;
        end
        if (c0_q.size() != 0 || c1_hdr_q.size() != 0 || host_req_valid) begin
            report_timeout("draining both buffers");
        end
    endtask

    // ========================================
    // Checking process
    // ========================================

    // Outputs and inputs are both stable at the falling edge, and what is
    // seen here is what the next rising edge acts on
    always @(negedge clk) begin : compare_proc
        logic ch;
        if (reset) begin
            c0_q.delete();
            c1_hdr_q.delete();
            c1_data_q.delete();
            c1_kind_q.delete();
            grant_q.delete();
            pref_model = PREFER_C0;
            held       = 1'b0;
            held_c1    = 1'b0;
            check_flag("valid in reset", 1'b0, host_req_valid);
            check_flag("c0 alm_full in reset", 1'b0, c0_tx_alm_full);
            check_flag("c1 alm_full in reset", 1'b0, c1_tx_alm_full);
        end else begin
            check_flag("c0 alm_full", expect_alm_full(c0_q.size()), c0_tx_alm_full);
            check_flag("c1 alm_full", expect_alm_full(c1_hdr_q.size()), c1_tx_alm_full);
            check_flag("host valid", (c0_q.size() != 0) || (c1_hdr_q.size() != 0),
                       host_req_valid);
            if (host_req_valid) begin
                ch = pick_channel(c0_q.size() != 0, c1_hdr_q.size() != 0,
                                  pref_model, held, held_c1);
                if (!ch) begin
                    check_hdr("read header", c0_q[0], host_req_hdr);
                    check_data("read data", '0, host_req_data);
                    check_kind("read kind", KIND_READ, host_req_kind);
                end else begin
                    check_hdr("channel 1 header", c1_hdr_q[0], host_req_hdr);
                    check_kind("channel 1 kind", c1_kind_q[0], host_req_kind);
                    if (c1_kind_q[0] == KIND_WRITE) begin
                        check_data("write data", c1_data_q[0], host_req_data);
                    end
                end
                if (host_req_ready) begin
                    // Accepted at the coming edge, so the other channel is preferred next
                    if (!ch) begin
                        c0_q.delete(0);
                    end else begin
                        c1_hdr_q.delete(0);
                        c1_data_q.delete(0);
                        c1_kind_q.delete(0);
                    end
                    pref_model = ch ? PREFER_C0 : PREFER_C1;
                    held       = 1'b0;
                    recv_count++;
                    // The grant seen on the host port, where only channel 0 carries reads
                    if (record_grants && grant_q.size() < 16) begin
                        grant_q.push_back(host_req_kind != KIND_READ);
                    end
                end else begin
                    held    = 1'b1;
                    held_c1 = ch;
                end
            end
            // Requests on the inputs now enter the buffers at the coming edge
            if (c0_tx_rd_valid) c0_q.push_back(c0_tx_hdr);
            if (c1_tx_wr_valid || c1_tx_ir_valid) begin
                c1_hdr_q.push_back(c1_tx_hdr);
                c1_data_q.push_back(c1_tx_data);
                c1_kind_q.push_back(c1_tx_wr_valid ? KIND_WRITE : KIND_INTR);
            end
        end
    end

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        int i;
        seed           = 32'h1862;
        reset          = 1'b1;
        c0_tx_hdr      = '0;
        c0_tx_rd_valid = 1'b0;
        c1_tx_hdr      = '0;
        c1_tx_data     = '0;
        c1_tx_wr_valid = 1'b0;
        c1_tx_ir_valid = 1'b0;
        host_req_ready = 1'b0;
        issued_count   = 0;
        recv_count     = 0;
        record_grants  = 1'b0;

        test_name = "reset";
        apply_reset();
        next_cycle();

        // Reads pile up behind a stalled host until almost-full, then drain
        test_name      = "c0_alone";
        host_req_ready = 1'b0;
        fill_channels(1'b1, 1'b0);
        drain();

        test_name = "c1_alone";
        for (i = 0; i < 40; i++) begin
            host_req_ready = ($random(seed) & 1) != 0;
            if (($random(seed) & 1) != 0) issue_c1(($random(seed) & 1) != 0);
            next_cycle();
        end
        drain();

        // A fresh reset puts the preference back on channel 0
        test_name = "both_full";
        apply_reset();
        host_req_ready = 1'b0;
        record_grants  = 1'b1;
        fill_channels(1'b1, 1'b1);
        host_req_ready = 1'b1;
        for (i = 0; i < 24; i++) begin
            issue_c0();
            issue_c1(($random(seed) & 1) != 0);
            next_cycle();
        end
        record_grants = 1'b0;
        drain();
        for (i = 0; i < 16; i++) begin
            check_flag("grant order", (i % 2) == 1, grant_q[i]);
        end

        test_name = "random_traffic";
        for (i = 0; i < 300; i++) begin
            host_req_ready = ($random(seed) & 3) != 0;
            if (($random(seed) & 1) != 0) issue_c0();
            if (($random(seed) & 1) != 0) issue_c1(($random(seed) & 1) != 0);
            next_cycle();
        end
        drain();

        if (issued_count == recv_count) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Mismatch in request count: expected %0d, actual %0d",
                     issued_count, recv_count);
            $display("TEST RESULT: FAIL");
            $fatal(1, "not every request reached the host");
        end
    end

endmodule

//--- flist.f
+incdir+dv
common/cci_shim_pkg.sv
common/cci_req_if.sv
verilog/req_fifo.sv
shim_buffer/shim_buffer_afu.sv
tx_arbiter/tx_arbiter.sv
verilog/cci_shim_top.sv
dv/cci_shim_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the request shim testbench with Verilator and runs it.
# The simulation exits with a failing status on any error.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cci_shim_tb \
    -Mdir obj_dir \
    -f flist.f

./obj_dir/Vcci_shim_tb

//--- shim_buffer/shim_buffer_afu.sv
`timescale 1ns/1ps

// Accelerator side request buffering.
// Each Tx channel feeds its own FIFO and the FIFO heads are offered to the
// scheduler through the two head interfaces. A request only leaves a
// buffer when the scheduler pops it with deq
module shim_buffer_afu import cci_shim_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // Channel 0 read requests
    input  cci_hdr_t  c0_tx_hdr,
    input  logic      c0_tx_rd_valid,
    output logic      c0_tx_alm_full,

    // Channel 1 write and interrupt requests
    input  cci_hdr_t  c1_tx_hdr,
    input  cci_data_t c1_tx_data,
    input  logic      c1_tx_wr_valid,
    input  logic      c1_tx_ir_valid,
    output logic      c1_tx_alm_full,

    // Buffer heads toward the scheduler
    cci_req_if.buffer c0_head,
    cci_req_if.buffer c1_head
);

    // ========================================
    // Channel 0 buffer
    // ========================================

    // Reads carry no payload so only the header is stored
    req_fifo #(
        .N_DATA_BITS (C0_ENTRY_BITS)
    ) c0_fifo (
        .clk         (clk),
        .reset       (reset),
        .enq_data    (c0_tx_hdr),
        .enq_en      (c0_tx_rd_valid),
        .deq_en      (c0_head.deq),
        .first       (c0_head.hdr),
        .not_empty   (c0_head.valid),
        .almost_full (c0_tx_alm_full)
    );

    // Every channel 0 request is a read with no data
    assign c0_head.kind = KIND_READ;
    assign c0_head.data = '0;

    // ========================================
    // Channel 1 buffer
    // ========================================

    logic                     c1_enq_en;
    logic [C1_ENTRY_BITS-1:0] c1_first;
    logic                     c1_wr_bit;

    // Either valid bit means a request is present on channel 1
    assign c1_enq_en = c1_tx_wr_valid || c1_tx_ir_valid;

    // Entry layout is header, then data, then the write and interrupt bits
    req_fifo #(
        .N_DATA_BITS (C1_ENTRY_BITS)
    ) c1_fifo (
        .clk         (clk),
        .reset       (reset),
        .enq_data    ({c1_tx_hdr, c1_tx_data, c1_tx_wr_valid, c1_tx_ir_valid}),
        .enq_en      (c1_enq_en),
        .deq_en      (c1_head.deq),
        .first       (c1_first),
        .not_empty   (c1_head.valid),
        .almost_full (c1_tx_alm_full)
    );

    // Split the head entry with the same layout used on enqueue.
    // The interrupt bit sits lowest and is implied by a clear write bit
    assign {c1_head.hdr, c1_head.data, c1_wr_bit} = c1_first[C1_ENTRY_BITS-1:1];

    // A set write bit marks a write, anything else stored is an interrupt
    assign c1_head.kind = c1_wr_bit ? KIND_WRITE : KIND_INTR;

    // ========================================
    // Checks
    // ========================================

    // The accelerator may never issue a write and an interrupt together
    c1_kind_in_check: assert property (
        @(posedge clk) disable iff (reset)
        !(c1_tx_wr_valid && c1_tx_ir_valid)
    );

endmodule

//--- tx_arbiter/tx_arbiter.sv
`timescale 1ns/1ps

// Round-robin scheduler for the two buffer heads.
// The chosen head drives the host port directly, so the host request is
// combinational from the heads and the state registers. A stalled request
// keeps its grant until the host takes it
module tx_arbiter import cci_shim_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    // Buffer heads
    cci_req_if.scheduler c0_head,
    cci_req_if.scheduler c1_head,

    // Host request port
    output logic         host_req_valid,
    output cci_hdr_t     host_req_hdr,
    output cci_data_t    host_req_data,
    output req_kind_t    host_req_kind,
    input  logic         host_req_ready
);

    // Channel that wins the next tie
    arb_state_t state_q;

    // Set while an offered request waits for ready
    logic lock_q;
    // Channel that owns the waiting request, meaningful only under lock
    logic grant_c1_q;

    // Channel picked this cycle, high for channel 1
    logic sel_c1;
    logic xfer;

    // ========================================
    // Channel selection
    // ========================================

    always_comb begin
        if (lock_q) begin
            // A stalled request is never swapped out
            sel_c1 = grant_c1_q;
        end else if (c0_head.valid && c1_head.valid) begin
            sel_c1 = (state_q == PREFER_C1);
        end else begin
            // With one head or none the valid one wins
            sel_c1 = c1_head.valid;
        end
    end

    // The selected head goes straight to the host
    assign host_req_valid = sel_c1 ? c1_head.valid : c0_head.valid;
    assign host_req_hdr   = sel_c1 ? c1_head.hdr   : c0_head.hdr;
    assign host_req_data  = sel_c1 ? c1_head.data  : c0_head.data;
    assign host_req_kind  = sel_c1 ? c1_head.kind  : c0_head.kind;

    // A transfer happens on an edge with both valid and ready
    assign xfer = host_req_valid && host_req_ready;

    // Pop only the head that the host just took
    assign c0_head.deq = xfer && !sel_c1;
    assign c1_head.deq = xfer && sel_c1;

    // ========================================
    // State
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= PREFER_C0;
            lock_q     <= 1'b0;
            grant_c1_q <= 1'b0;
        end else begin
            // After serving one channel the other gets the next tie
            if (xfer) begin
                state_q <= sel_c1 ? PREFER_C0 : PREFER_C1;
            end
            lock_q     <= host_req_valid && !host_req_ready;
            grant_c1_q <= sel_c1;
        end
    end

    // ========================================
    // Checks
    // ========================================

    // An offered request holds still until the host accepts it
    host_stable_check: assert property (
        @(posedge clk) disable iff (reset)
        (host_req_valid && !host_req_ready) |=>
            (host_req_valid && $stable(host_req_hdr) && $stable(host_req_data)
             && $stable(host_req_kind))
    );

endmodule

//--- verilog/cci_shim_top.sv
`timescale 1ns/1ps

// Request path from the accelerator to the host.
// Two channel buffers sit side by side and the scheduler merges their
// heads onto the single host request port
module cci_shim_top import cci_shim_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // Accelerator channel 0
    input  cci_hdr_t  c0_tx_hdr,
    input  logic      c0_tx_rd_valid,
    output logic      c0_tx_alm_full,

    // Accelerator channel 1
    input  cci_hdr_t  c1_tx_hdr,
    input  cci_data_t c1_tx_data,
    input  logic      c1_tx_wr_valid,
    input  logic      c1_tx_ir_valid,
    output logic      c1_tx_alm_full,

    // Host request port
    output logic      host_req_valid,
    output cci_hdr_t  host_req_hdr,
    output cci_data_t host_req_data,
    output req_kind_t host_req_kind,
    input  logic      host_req_ready
);

    // ========================================
    // Buffer heads
    // ========================================

    cci_req_if c0_head ();
    cci_req_if c1_head ();

    // ========================================
    // Channel buffers
    // ========================================

    shim_buffer_afu u_buffer (
        .clk            (clk),
        .reset          (reset),
        .c0_tx_hdr      (c0_tx_hdr),
        .c0_tx_rd_valid (c0_tx_rd_valid),
        .c0_tx_alm_full (c0_tx_alm_full),
        .c1_tx_hdr      (c1_tx_hdr),
        .c1_tx_data     (c1_tx_data),
        .c1_tx_wr_valid (c1_tx_wr_valid),
        .c1_tx_ir_valid (c1_tx_ir_valid),
        .c1_tx_alm_full (c1_tx_alm_full),
        .c0_head        (c0_head.buffer),
        .c1_head        (c1_head.buffer)
    );

    // ========================================
    // Scheduler
    // ========================================

    tx_arbiter u_arbiter (
        .clk            (clk),
        .reset          (reset),
        .c0_head        (c0_head.scheduler),
        .c1_head        (c1_head.scheduler),
        .host_req_valid (host_req_valid),
        .host_req_hdr   (host_req_hdr),
        .host_req_data  (host_req_data),
        .host_req_kind  (host_req_kind),
        .host_req_ready (host_req_ready)
    );

endmodule

//--- verilog/req_fifo.sv
`timescale 1ns/1ps

// Small FIFO built from a circular array of registers.
// Occupancy lives in its own register so that almost_full and not_empty
// come straight from flops and never from the enqueue or dequeue strobes
module req_fifo import cci_shim_pkg::*; #(
    parameter int N_DATA_BITS = HDR_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    input  logic                   deq_en,

    output logic [N_DATA_BITS-1:0] first,
    output logic                   not_empty,
    output logic                   almost_full
);

    // Last legal pointer value, where the pointers wrap back to zero
    localparam logic [BUF_PTR_WIDTH-1:0] LAST_PTR = BUF_PTR_WIDTH'(BUF_DEPTH - 1);

    // Storage array
    logic [N_DATA_BITS-1:0] mem [BUF_DEPTH];

    logic [BUF_PTR_WIDTH-1:0] wr_ptr_q;
    logic [BUF_PTR_WIDTH-1:0] rd_ptr_q;
    buf_count_t               count_q;
    logic                     full;

    // ========================================
    // Storage
    // ========================================

    // Slots are written as they arrive and carry no reset
    always_ff @(posedge clk) begin
        if (enq_en) begin
            mem[wr_ptr_q] <= enq_data;
        end
    end

    // The head is a read from the array at the read pointer
    assign first = mem[rd_ptr_q];

    // ========================================
    // Pointers and occupancy
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq_en) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (deq_en) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            // A simultaneous enqueue and dequeue leaves the count alone
            case ({enq_en, deq_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign not_empty = (count_q != '0);
    assign full      = (count_q == buf_count_t'(BUF_DEPTH));

    // Raised with ALM_FULL_SLOTS or fewer free slots left.
    // This leaves room for the requests already on their way in
    assign almost_full = (buf_count_t'(BUF_DEPTH) - count_q) <= buf_count_t'(ALM_FULL_SLOTS);

    // ========================================
    // Checks
    // ========================================

    // The producer has no ready signal and must honour almost_full
    overflow_check: assert property (
        @(posedge clk) disable iff (reset)
        enq_en |-> !full
    );

    // The consumer may only pop a head that exists
    underflow_check: assert property (
        @(posedge clk) disable iff (reset)
        deq_en |-> not_empty
    );

endmodule
